/* sim/adder_checker.sv */
// Watches the adder ports, models each issued operation and compares the results in issue order
`timescale 1ns/1ps
`default_nettype none

module adder_checker (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  adder_pkg::op_e                      op,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   a,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   b,
	input  logic                                cin,
	input  logic                                out_valid,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   sum,
	input  logic                                cout,
	input  logic                                end_check,
	output int                                  error_count,
	output logic                                report_done
);

	localparam int LATENCY = 6;

	// Outstanding operations, oldest first
	logic [adder_pkg::ADDER_WIDTH:0]   exp_q [$];
	logic [adder_pkg::ADDER_WIDTH-1:0] a_q [$];
	logic [adder_pkg::ADDER_WIDTH-1:0] b_q [$];
	logic                              sub_q [$];
	logic                              cin_q [$];
	longint                            cyc_q [$];

	longint                            cycle;
	int                                issued;
	int                                compared;
	int                                mismatches;
	int                                failures;
	logic                              prev_rst_low;
	logic [adder_pkg::ADDER_WIDTH:0]   exp_val;
	logic [adder_pkg::ADDER_WIDTH-1:0] exp_a;
	logic [adder_pkg::ADDER_WIDTH-1:0] exp_b;
	logic                              exp_sub;
	logic                              exp_cin;
	longint                            exp_cyc;

	// {cout, sum} of a + b + cin, with b inverted for SUB
	function automatic logic [adder_pkg::ADDER_WIDTH:0] model_result(
		input logic                              is_sub,
		input logic [adder_pkg::ADDER_WIDTH-1:0] x,
		input logic [adder_pkg::ADDER_WIDTH-1:0] y,
		input logic                              c
	);
		logic [adder_pkg::ADDER_WIDTH-1:0] y_eff;
		y_eff = is_sub ? ~y : y;
		return {1'b0, x} + {1'b0, y_eff} + {{adder_pkg::ADDER_WIDTH{1'b0}}, c};
	endfunction

	task automatic flag_failure(input string msg);
		$display("Checker failure at %0t ns: %s", $time, msg);
		failures++;
	endtask

	task automatic pop_oldest();
		exp_val = exp_q.pop_front();
		exp_a   = a_q.pop_front();
		exp_b   = b_q.pop_front();
		exp_sub = sub_q.pop_front();
		exp_cin = cin_q.pop_front();
		exp_cyc = cyc_q.pop_front();
	endtask

	initial begin
		cycle        = 0;
		issued       = 0;
		compared     = 0;
		mismatches   = 0;
		failures     = 0;
		prev_rst_low = 1'b0;
		error_count  = 0;
		report_done  = 1'b0;
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (prev_rst_low && out_valid !== 1'b0)
			flag_failure("out_valid is high on an edge right after reset was sampled");
		prev_rst_low = !rst_n;

		if (!rst_n) begin
			// Reset drops everything in flight
			exp_q.delete();
			a_q.delete();
			b_q.delete();
			sub_q.delete();
			cin_q.delete();
			cyc_q.delete();
		end else begin
			if (out_valid === 1'b1) begin
				if (cyc_q.size() == 0) begin
					flag_failure("out_valid is high with no operation outstanding");
				end else begin
					pop_oldest();
					compared++;
					if ({cout, sum} !== exp_val) begin
						mismatches++;
						$display("ERR t=%0t %s a=%h b=%h cin=%b expected sum=%h cout=%b got sum=%h cout=%b",
							$time, exp_sub ? "SUB" : "ADD", exp_a, exp_b, exp_cin,
							exp_val[adder_pkg::ADDER_WIDTH-1:0], exp_val[adder_pkg::ADDER_WIDTH],
							sum, cout);
					end
					if (cycle - exp_cyc != LATENCY)
						flag_failure($sformatf("result arrived %0d cycles after issue instead of %0d",
							cycle - exp_cyc, LATENCY));
				end
			end

			if (in_valid === 1'b1) begin
				exp_q.push_back(model_result(op == adder_pkg::OP_SUB, a, b, cin));
				a_q.push_back(a);
				b_q.push_back(b);
				sub_q.push_back(op == adder_pkg::OP_SUB);
				cin_q.push_back(cin);
				cyc_q.push_back(cycle);
				issued++;
				if (cyc_q.size() > LATENCY)
					flag_failure("more than six operations are outstanding");
			end
		end

		if (end_check && !report_done) begin
			if (cyc_q.size() != 0)
				flag_failure($sformatf("%0d operations still outstanding at end of run",
					cyc_q.size()));
			$display("Checker summary: issued %0d, compared %0d, mismatches %0d, other failures %0d",
				issued, compared, mismatches, failures);
			report_done <= 1'b1;
		end

		error_count <= mismatches + failures;
	end

endmodule : adder_checker

`default_nettype wire

/* sim/tb_prefix_adder.sv */
// Testbench top for the pipelined prefix adder; drives seeded random and directed operations
`timescale 1ns/1ps
`default_nettype none

module tb_prefix_adder;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 8;
	localparam int LATENCY        = 6;
	localparam int unsigned SEED  = 32'hd5ac1b4c;

	// Phase lengths in operations
	localparam int N_B2B          = 1000;
	localparam int N_GAP          = 800;
	localparam int MAX_GAP        = 3;
	localparam int N_CHAIN        = 4 * (adder_pkg::ADDER_WIDTH + 1);
	localparam int N_SUB          = 600;
	localparam int N_PRE_RST      = 20;
	localparam int MID_RST_CYCLES = 3;
	localparam int N_POST_RST     = 500;
	localparam int DRAIN_EXTRA    = 10;

	// Worst case with every gap at its longest
	localparam int TEST_CYCLES = N_B2B + N_GAP * (MAX_GAP + 1) + N_CHAIN + N_SUB + N_PRE_RST +
		MID_RST_CYCLES + N_POST_RST * (MAX_GAP + 1) + DRAIN_EXTRA;
	localparam int WATCHDOG_NS = (TEST_CYCLES + RESET_CYCLES + LATENCY + 50) * CLK_PERIOD;

	logic                              clk;
	logic                              rst_n;
	logic                              in_valid;
	adder_pkg::op_e                    op;
	logic [adder_pkg::ADDER_WIDTH-1:0] a;
	logic [adder_pkg::ADDER_WIDTH-1:0] b;
	logic                              cin;
	logic                              out_valid;
	logic [adder_pkg::ADDER_WIDTH-1:0] sum;
	logic                              cout;
	logic                              end_check;
	int                                error_count;
	logic                              report_done;
	int                                pos;
	logic [adder_pkg::ADDER_WIDTH:0]   span_bit;
	logic [adder_pkg::ADDER_WIDTH:0]   span_mask;

	prefix_adder_top u_prefix_adder_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.out_valid (out_valid),
		.sum       (sum),
		.cout      (cout)
	);

	adder_checker u_adder_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.op          (op),
		.a           (a),
		.b           (b),
		.cin         (cin),
		.out_valid   (out_valid),
		.sum         (sum),
		.cout        (cout),
		.end_check   (end_check),
		.error_count (error_count),
		.report_done (report_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [adder_pkg::ADDER_WIDTH-1:0] rand_operand();
		logic [31:0] r;
		r = $urandom;
		return r[adder_pkg::ADDER_WIDTH-1:0];
	endfunction

	task automatic issue_op(input adder_pkg::op_e o, input logic [adder_pkg::ADDER_WIDTH-1:0] x,
		input logic [adder_pkg::ADDER_WIDTH-1:0] y, input logic c);
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= o;
		a        <= x;
		b        <= y;
		cin      <= c;
	endtask

	task automatic issue_random();
		issue_op(($urandom % 2) ? adder_pkg::OP_SUB : adder_pkg::OP_ADD,
			rand_operand(), rand_operand(), $urandom % 2);
	endtask

	// Operands keep moving while nothing is issued
	task automatic idle_cycle();
		@(posedge clk);
		in_valid <= 1'b0;
		op       <= ($urandom % 2) ? adder_pkg::OP_SUB : adder_pkg::OP_ADD;
		a        <= rand_operand();
		b        <= rand_operand();
		cin      <= $urandom % 2;
	endtask

	task automatic random_gap();
		repeat ($urandom % (MAX_GAP + 1)) idle_cycle();
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		op        = adder_pkg::OP_ADD;
		a         = '0;
		b         = '0;
		cin       = 1'b0;
		end_check = 1'b0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// Full rate, six in flight
		repeat (N_B2B) issue_random();

		repeat (N_GAP) begin
			issue_random();
			random_gap();
		end

		// Carry runs ending or starting at every column
		for (pos = 0; pos <= adder_pkg::ADDER_WIDTH; pos++) begin
			span_bit  = 1 << pos;
			span_mask = span_bit - 1;
			issue_op(adder_pkg::OP_ADD, span_mask[11:0], 12'h000, 1'b1);
			issue_op(adder_pkg::OP_ADD, 12'hfff, span_bit[11:0], 1'b0);
			issue_op(adder_pkg::OP_SUB, 12'h000, ~span_mask[11:0], 1'b1);
			issue_op(adder_pkg::OP_ADD, ~span_mask[11:0], span_mask[11:0], 1'b1);
		end

		// Plain subtraction a - b
		repeat (N_SUB) issue_op(adder_pkg::OP_SUB, rand_operand(), rand_operand(), 1'b1);

		// Reset while the pipeline is full
		repeat (N_PRE_RST) issue_random();
		rst_n <= 1'b0;
		repeat (MID_RST_CYCLES) issue_random();
		rst_n <= 1'b1;

		repeat (N_POST_RST) begin
			issue_random();
			random_gap();
		end

		// Fixed latency, so the last result is out after LATENCY idle cycles
		repeat (LATENCY + DRAIN_EXTRA) idle_cycle();
		end_check <= 1'b1;
		do @(posedge clk); while (report_done !== 1'b1);

		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : tb_prefix_adder

`default_nettype wire

/* sources.f */
src/adder_pkg.sv
src/pg_precompute.sv
src/knowles_level.sv
src/sum_postcompute.sv
src/prefix_adder_top.sv
sim/adder_checker.sv
sim/tb_prefix_adder.sv

/* src/adder_pkg.sv */
// Shared widths, prefix tree dimensions and opcode type for the pipelined prefix adder and its testbench
`default_nettype none

package adder_pkg;

	// Operand and sum width
	localparam int ADDER_WIDTH = 12;

	// Column 0 carries cin, columns 1..12 follow operand bits 0..11
	localparam int PG_COLUMNS = ADDER_WIDTH + 1;

	// Knowles [1,1,1,1] tree, spans 1, 2, 4 and 8
	localparam int PREFIX_LEVELS = 4;

	// Operation select
	// SUB inverts b before the tree; cin = 1 then gives a - b
	typedef enum logic [0:0] {
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} op_e;

endpackage : adder_pkg

`default_nettype wire

/* src/knowles_level.sv */
// One registered Knowles prefix level; merges every column with the column SPAN below it
`timescale 1ns/1ps
`default_nettype none

module knowles_level #(
	parameter int SPAN = 1
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  logic [adder_pkg::PG_COLUMNS-1:0]    gen_in,
	input  logic [adder_pkg::PG_COLUMNS-1:0]    prop_in,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   half_sum_in,
	output logic                                out_valid,
	output logic [adder_pkg::PG_COLUMNS-1:0]    gen_out,
	output logic [adder_pkg::PG_COLUMNS-1:0]    prop_out,
	output logic [adder_pkg::ADDER_WIDTH-1:0]   half_sum_out
);

	logic [adder_pkg::PG_COLUMNS-1:0] gen_next;
	logic [adder_pkg::PG_COLUMNS-1:0] prop_next;

	genvar col;

	generate
		for (col = 0; col < adder_pkg::PG_COLUMNS; col++) begin : g_col
			if (col < SPAN) begin : g_done
				// Group already reaches column 0
				assign gen_next[col]  = gen_in[col];
				assign prop_next[col] = prop_in[col];
			end else if (col < 2 * SPAN) begin : g_grey
				// Lower partner is complete, so only the group generate matters.
				// The merged group contains column 0, whose propagate is 0.
				assign gen_next[col]  = gen_in[col] | (prop_in[col] & gen_in[col-SPAN]);
				assign prop_next[col] = 1'b0;
			end else begin : g_black
				// Both halves still open
				assign gen_next[col]  = gen_in[col] | (prop_in[col] & gen_in[col-SPAN]);
				assign prop_next[col] = prop_in[col] & prop_in[col-SPAN];
			end
		end
	endgenerate

	// Valid strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Group terms and delayed half-sum
	always_ff @(posedge clk) begin
		gen_out      <= gen_next;
		prop_out     <= prop_next;
		half_sum_out <= half_sum_in;
	end

	// Column 0 must stay a pure generator through every level
	a_col0_prop_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |-> (prop_in[0] == 1'b0)
	) else $error("knowles_level span %0d: column 0 propagate set", SPAN);

endmodule : knowles_level

`default_nettype wire

/* src/pg_precompute.sv */
// First pipeline stage of the prefix adder; registers per-column generate/propagate and half-sum bits
`timescale 1ns/1ps
`default_nettype none

module pg_precompute (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  adder_pkg::op_e                      op,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   a,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   b,
	input  logic                                cin,
	output logic                                pg_valid,
	output logic [adder_pkg::PG_COLUMNS-1:0]    gen,
	output logic [adder_pkg::PG_COLUMNS-1:0]    prop,
	output logic [adder_pkg::ADDER_WIDTH-1:0]   half_sum
);

	logic [adder_pkg::ADDER_WIDTH-1:0] b_eff;
	logic [adder_pkg::ADDER_WIDTH-1:0] bit_gen;
	logic [adder_pkg::ADDER_WIDTH-1:0] bit_prop;

	// Subtraction uses the one's complement of b, cin supplies the +1
	assign b_eff = (op == adder_pkg::OP_SUB) ? ~b : b;

	assign bit_gen  = a & b_eff;
	assign bit_prop = a ^ b_eff;

	// Valid strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pg_valid <= 1'b0;
		end else begin
			pg_valid <= in_valid;
		end
	end

	// Column 0 acts as a pure generator for cin
	always_ff @(posedge clk) begin
		gen      <= {bit_gen, cin};
		prop     <= {bit_prop, 1'b0};
		half_sum <= bit_prop;
	end

	// Opcode must decode to a known operation when issued
	a_op_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(op)
	) else $error("pg_precompute: unknown opcode %b with in_valid", op);

endmodule : pg_precompute

`default_nettype wire

/* src/prefix_adder_top.sv */
// Top of the 6-stage pipelined Knowles adder/subtractor; one operation accepted per cycle
`timescale 1ns/1ps
`default_nettype none

module prefix_adder_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  adder_pkg::op_e                      op,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   a,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   b,
	input  logic                                cin,
	output logic                                out_valid,
	output logic [adder_pkg::ADDER_WIDTH-1:0]   sum,
	output logic                                cout
);

	// Stage boundary 0 is the precompute output, boundary N the output of level N
	logic                              valid_s    [0:adder_pkg::PREFIX_LEVELS];
	logic [adder_pkg::PG_COLUMNS-1:0]  gen_s      [0:adder_pkg::PREFIX_LEVELS];
	logic [adder_pkg::PG_COLUMNS-1:0]  prop_s     [0:adder_pkg::PREFIX_LEVELS];
	logic [adder_pkg::ADDER_WIDTH-1:0] half_sum_s [0:adder_pkg::PREFIX_LEVELS];

	pg_precompute u_pg_precompute (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.op       (op),
		.a        (a),
		.b        (b),
		.cin      (cin),
		.pg_valid (valid_s[0]),
		.gen      (gen_s[0]),
		.prop     (prop_s[0]),
		.half_sum (half_sum_s[0])
	);

	// Spans 1, 2, 4, 8
	genvar lvl;
	generate
		for (lvl = 0; lvl < adder_pkg::PREFIX_LEVELS; lvl++) begin : g_level
			knowles_level #(
				.SPAN (1 << lvl)
			) u_knowles_level (
				.clk          (clk),
				.rst_n        (rst_n),
				.in_valid     (valid_s[lvl]),
				.gen_in       (gen_s[lvl]),
				.prop_in      (prop_s[lvl]),
				.half_sum_in  (half_sum_s[lvl]),
				.out_valid    (valid_s[lvl+1]),
				.gen_out      (gen_s[lvl+1]),
				.prop_out     (prop_s[lvl+1]),
				.half_sum_out (half_sum_s[lvl+1])
			);
		end
	endgenerate

	sum_postcompute u_sum_postcompute (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (valid_s[adder_pkg::PREFIX_LEVELS]),
		.gen_in      (gen_s[adder_pkg::PREFIX_LEVELS]),
		.prop_in     (prop_s[adder_pkg::PREFIX_LEVELS]),
		.half_sum_in (half_sum_s[adder_pkg::PREFIX_LEVELS]),
		.out_valid   (out_valid),
		.sum         (sum),
		.cout        (cout)
	);

endmodule : prefix_adder_top

`default_nettype wire

/* src/sum_postcompute.sv */
// Last pipeline stage of the prefix adder; forms sum and carry-out from the finished carries
`timescale 1ns/1ps
`default_nettype none

module sum_postcompute (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	input  logic [adder_pkg::PG_COLUMNS-1:0]    gen_in,
	input  logic [adder_pkg::PG_COLUMNS-1:0]    prop_in,
	input  logic [adder_pkg::ADDER_WIDTH-1:0]   half_sum_in,
	output logic                                out_valid,
	output logic [adder_pkg::ADDER_WIDTH-1:0]   sum,
	output logic                                cout
);

	logic [adder_pkg::ADDER_WIDTH-1:0] carry;
	logic [adder_pkg::ADDER_WIDTH-1:0] sum_next;
	logic                              cout_next;

	// Column j holds the group through column 0, i.e. the carry into bit j
	assign carry    = gen_in[adder_pkg::ADDER_WIDTH-1:0];
	assign sum_next = half_sum_in ^ carry;

	// Top column already spans every column down to cin
	assign cout_next = gen_in[adder_pkg::PG_COLUMNS-1];

	// Valid strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Result registers
	always_ff @(posedge clk) begin
		sum  <= sum_next;
		cout <= cout_next;
	end

	// Any X here traces back to an unknown operand at issue six cycles earlier
	a_result_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({sum, cout})
	) else $error("sum_postcompute: unknown result bits sum=%h cout=%b", sum, cout);

endmodule : sum_postcompute

`default_nettype wire
